//--- Makefile
TOP := tb_lockstep

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

//--- flist.f
+incdir+hw
hw/lockstep_pkg.sv
hw/resp_tap_if.sv
hw/shadow_reset_seq.sv
hw/input_delay_line.sv
hw/bus_intg_check.sv
hw/output_compare.sv
hw/lockstep_top.sv
verification/lockstep_checker.sv
verification/tb_lockstep.sv

//--- hw/bus_intg_check.sv
// Any nonzero syndrome counts as an error; single and double bit faults are not told apart
`timescale 1ns/10ps

module bus_intg_check (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  lockstep_pkg::intg_t instr_rdata_intg_i,
  input  lockstep_pkg::intg_t data_rdata_intg_i,
  resp_tap_if.chk             resp,
  input  lockstep_pkg::word_t data_wdata_i,
  output lockstep_pkg::intg_t data_wdata_intg_o,
  output logic                intg_err_o
);
  import lockstep_pkg::*;

  intg_t instr_intg_q, data_intg_q;
  logic  instr_mismatch, data_mismatch;

  // Hsiao parity of one word
  function automatic intg_t calc_intg(word_t data);
    intg_t intg;
    for (int k = 0; k < $bits(intg_t); k++) begin
      intg[k] = ^(data & INTG_MASK[k]);
    end
    return intg;
  endfunction

  ////////////////////
  // Read check
  ////////////////////

  // One stage, same as the tap
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_intg_q <= '0;
      data_intg_q  <= '0;
    end else begin
      instr_intg_q <= instr_rdata_intg_i;
      data_intg_q  <= data_rdata_intg_i;
    end
  end

  assign instr_mismatch = (calc_intg(resp.instr_rdata) != instr_intg_q);
  assign data_mismatch  = (calc_intg(resp.data_rdata) != data_intg_q);

  // Only qualified responses count
  assign intg_err_o = (resp.instr_rvalid & instr_mismatch) |
                      (resp.data_rvalid & data_mismatch);

  ////////////////////
  // Write generation
  ////////////////////

  assign data_wdata_intg_o = calc_intg(data_wdata_i);

endmodule

//--- hw/input_delay_line.sv
// Shadow inputs lag by LOCKSTEP_OFFSET cycles and are all low out of reset; no back-pressure
`timescale 1ns/10ps
`include "lockstep_config.svh"

module input_delay_line #(
  parameter int unsigned LOCKSTEP_OFFSET = `LOCKSTEP_OFFSET
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  logic                instr_err_i,
  input  lockstep_pkg::word_t instr_rdata_i,
  input  logic                data_gnt_i,
  input  logic                data_rvalid_i,
  input  logic                data_err_i,
  input  lockstep_pkg::word_t data_rdata_i,
  input  logic                irq_software_i,
  input  logic                irq_timer_i,
  input  logic                irq_external_i,
  input  logic                irq_nm_i,
  input  logic                debug_req_i,
  input  logic                fetch_enable_i,
  output logic                shadow_instr_gnt_o,
  output logic                shadow_instr_rvalid_o,
  output logic                shadow_instr_err_o,
  output lockstep_pkg::word_t shadow_instr_rdata_o,
  output logic                shadow_data_gnt_o,
  output logic                shadow_data_rvalid_o,
  output logic                shadow_data_err_o,
  output lockstep_pkg::word_t shadow_data_rdata_o,
  output logic                shadow_irq_software_o,
  output logic                shadow_irq_timer_o,
  output logic                shadow_irq_external_o,
  output logic                shadow_irq_nm_o,
  output logic                shadow_debug_req_o,
  output logic                shadow_fetch_enable_o,
  resp_tap_if.tap             tap
);
  import lockstep_pkg::*;

  typedef struct packed {
    logic  instr_gnt;
    logic  instr_rvalid;
    logic  instr_err;
    word_t instr_rdata;
    logic  data_gnt;
    logic  data_rvalid;
    logic  data_err;
    word_t data_rdata;
    logic  irq_software;
    logic  irq_timer;
    logic  irq_external;
    logic  irq_nm;
    logic  debug_req;
    logic  fetch_enable;
  } in_bundle_t;

  in_bundle_t                       bundle_in;
  // Index LOCKSTEP_OFFSET-1 is the newest stage, 0 the oldest
  in_bundle_t [LOCKSTEP_OFFSET-1:0] stage_q;

  assign bundle_in = {instr_gnt_i, instr_rvalid_i, instr_err_i, instr_rdata_i,
                      data_gnt_i, data_rvalid_i, data_err_i, data_rdata_i,
                      irq_software_i, irq_timer_i, irq_external_i, irq_nm_i,
                      debug_req_i, fetch_enable_i};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else begin
      for (int unsigned i = 0; i < LOCKSTEP_OFFSET - 1; i++) begin
        stage_q[i] <= stage_q[i+1];
      end
      stage_q[LOCKSTEP_OFFSET-1] <= bundle_in;
    end
  end

  assign {shadow_instr_gnt_o, shadow_instr_rvalid_o, shadow_instr_err_o, shadow_instr_rdata_o,
          shadow_data_gnt_o, shadow_data_rvalid_o, shadow_data_err_o, shadow_data_rdata_o,
          shadow_irq_software_o, shadow_irq_timer_o, shadow_irq_external_o, shadow_irq_nm_o,
          shadow_debug_req_o, shadow_fetch_enable_o} = stage_q[0];

  // Newest stage lines up with the registered check bits
  assign tap.instr_rvalid = stage_q[LOCKSTEP_OFFSET-1].instr_rvalid;
  assign tap.instr_rdata  = stage_q[LOCKSTEP_OFFSET-1].instr_rdata;
  assign tap.data_rvalid  = stage_q[LOCKSTEP_OFFSET-1].data_rvalid;
  assign tap.data_rdata   = stage_q[LOCKSTEP_OFFSET-1].data_rdata;

endmodule

//--- hw/lockstep_config.svh
// LOCKSTEP_OFFSET must be 2 or more; the integrity code is fixed at 7 check bits per 32-bit word
`ifndef LOCKSTEP_CONFIG_SVH
`define LOCKSTEP_CONFIG_SVH

////////////////////
// Lockstep timing
////////////////////

// Cycles the shadow core runs behind the main core
`define LOCKSTEP_OFFSET 2

////////////////////
// Bus geometry
////////////////////

// Address and data word width
`define DATA_W 32

// Hsiao (39,32) check bits per word
`define INTG_W 7

// One enable per byte lane
`define BE_W 4

`endif

//--- hw/lockstep_pkg.sv
// Counter width follows the LOCKSTEP_OFFSET macro; masks are valid only for 32-bit data words
`include "lockstep_config.svh"

package lockstep_pkg;

  typedef logic [`DATA_W-1:0] word_t;
  typedef logic [`INTG_W-1:0] intg_t;
  typedef logic [`BE_W-1:0]   be_t;

  // Must reach LOCKSTEP_OFFSET-1
  typedef logic [$clog2(`LOCKSTEP_OFFSET+1)-1:0] offset_cnt_t;

  // Bit 0 releases the shadow reset, bit 1 enables comparison
  typedef enum logic [1:0] {
    SEQ_HOLD    = 2'b00,
    SEQ_RELEASE = 2'b01,
    SEQ_COMPARE = 2'b11
  } seq_state_e;

  ////////////////////
  // Integrity masks
  ////////////////////

  // Check bit k is the XOR of the data bits picked by mask k
  localparam word_t [`INTG_W-1:0] INTG_MASK = {
    32'h98505586,
    32'h2DCC624C,
    32'hC2C1323B,
    32'h31234ED1,
    32'h413D89AA,
    32'hDEBA8050,
    32'h2606BD25
  };

endpackage

//--- hw/lockstep_top.sv
// Shadow core sits outside; its requests must be driven LOCKSTEP_OFFSET cycles behind the main core
`timescale 1ns/10ps
`include "lockstep_config.svh"

module lockstep_top #(
  parameter int unsigned LOCKSTEP_OFFSET = `LOCKSTEP_OFFSET
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Main core requests
  input  logic                instr_req_i,
  input  lockstep_pkg::word_t instr_addr_i,
  input  logic                data_req_i,
  input  logic                data_we_i,
  input  lockstep_pkg::be_t   data_be_i,
  input  lockstep_pkg::word_t data_addr_i,
  input  lockstep_pkg::word_t data_wdata_i,
  output lockstep_pkg::intg_t data_wdata_intg_o,
  input  logic                irq_pending_i,
  input  logic                busy_i,
  // Main core responses
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  logic                instr_err_i,
  input  lockstep_pkg::word_t instr_rdata_i,
  input  lockstep_pkg::intg_t instr_rdata_intg_i,
  input  logic                data_gnt_i,
  input  logic                data_rvalid_i,
  input  logic                data_err_i,
  input  lockstep_pkg::word_t data_rdata_i,
  input  lockstep_pkg::intg_t data_rdata_intg_i,
  input  logic                irq_software_i,
  input  logic                irq_timer_i,
  input  logic                irq_external_i,
  input  logic                irq_nm_i,
  input  logic                debug_req_i,
  input  logic                fetch_enable_i,
  // Shadow core side
  output logic                shadow_rst_no,
  output logic                shadow_instr_gnt_o,
  output logic                shadow_instr_rvalid_o,
  output logic                shadow_instr_err_o,
  output lockstep_pkg::word_t shadow_instr_rdata_o,
  output logic                shadow_data_gnt_o,
  output logic                shadow_data_rvalid_o,
  output logic                shadow_data_err_o,
  output lockstep_pkg::word_t shadow_data_rdata_o,
  output logic                shadow_irq_software_o,
  output logic                shadow_irq_timer_o,
  output logic                shadow_irq_external_o,
  output logic                shadow_irq_nm_o,
  output logic                shadow_debug_req_o,
  output logic                shadow_fetch_enable_o,
  input  logic                shadow_instr_req_i,
  input  lockstep_pkg::word_t shadow_instr_addr_i,
  input  logic                shadow_data_req_i,
  input  logic                shadow_data_we_i,
  input  lockstep_pkg::be_t   shadow_data_be_i,
  input  lockstep_pkg::word_t shadow_data_addr_i,
  input  lockstep_pkg::word_t shadow_data_wdata_i,
  input  logic                shadow_irq_pending_i,
  input  logic                shadow_busy_i,
  input  logic                shadow_alert_minor_i,
  input  logic                shadow_alert_major_i,
  // Alerts
  output logic                alert_minor_o,
  output logic                alert_major_o
);

  logic cmp_en;
  logic mismatch;
  logic intg_err;

  resp_tap_if resp_tap ();

  shadow_reset_seq #(
    .LOCKSTEP_OFFSET (LOCKSTEP_OFFSET)
  ) u_reset_seq (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .shadow_rst_no (shadow_rst_no),
    .cmp_en_o      (cmp_en)
  );

  input_delay_line #(
    .LOCKSTEP_OFFSET (LOCKSTEP_OFFSET)
  ) u_input_delay (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .instr_gnt_i           (instr_gnt_i),
    .instr_rvalid_i        (instr_rvalid_i),
    .instr_err_i           (instr_err_i),
    .instr_rdata_i         (instr_rdata_i),
    .data_gnt_i            (data_gnt_i),
    .data_rvalid_i         (data_rvalid_i),
    .data_err_i            (data_err_i),
    .data_rdata_i          (data_rdata_i),
    .irq_software_i        (irq_software_i),
    .irq_timer_i           (irq_timer_i),
    .irq_external_i        (irq_external_i),
    .irq_nm_i              (irq_nm_i),
    .debug_req_i           (debug_req_i),
    .fetch_enable_i        (fetch_enable_i),
    .shadow_instr_gnt_o    (shadow_instr_gnt_o),
    .shadow_instr_rvalid_o (shadow_instr_rvalid_o),
    .shadow_instr_err_o    (shadow_instr_err_o),
    .shadow_instr_rdata_o  (shadow_instr_rdata_o),
    .shadow_data_gnt_o     (shadow_data_gnt_o),
    .shadow_data_rvalid_o  (shadow_data_rvalid_o),
    .shadow_data_err_o     (shadow_data_err_o),
    .shadow_data_rdata_o   (shadow_data_rdata_o),
    .shadow_irq_software_o (shadow_irq_software_o),
    .shadow_irq_timer_o    (shadow_irq_timer_o),
    .shadow_irq_external_o (shadow_irq_external_o),
    .shadow_irq_nm_o       (shadow_irq_nm_o),
    .shadow_debug_req_o    (shadow_debug_req_o),
    .shadow_fetch_enable_o (shadow_fetch_enable_o),
    .tap                   (resp_tap.tap)
  );

  bus_intg_check u_intg_check (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .instr_rdata_intg_i (instr_rdata_intg_i),
    .data_rdata_intg_i  (data_rdata_intg_i),
    .resp               (resp_tap.chk),
    .data_wdata_i       (data_wdata_i),
    .data_wdata_intg_o  (data_wdata_intg_o),
    .intg_err_o         (intg_err)
  );

  output_compare #(
    .LOCKSTEP_OFFSET (LOCKSTEP_OFFSET)
  ) u_output_compare (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .cmp_en_i             (cmp_en),
    .core_instr_req_i     (instr_req_i),
    .core_instr_addr_i    (instr_addr_i),
    .core_data_req_i      (data_req_i),
    .core_data_we_i       (data_we_i),
    .core_data_be_i       (data_be_i),
    .core_data_addr_i     (data_addr_i),
    .core_data_wdata_i    (data_wdata_i),
    .core_irq_pending_i   (irq_pending_i),
    .core_busy_i          (busy_i),
    .shadow_instr_req_i   (shadow_instr_req_i),
    .shadow_instr_addr_i  (shadow_instr_addr_i),
    .shadow_data_req_i    (shadow_data_req_i),
    .shadow_data_we_i     (shadow_data_we_i),
    .shadow_data_be_i     (shadow_data_be_i),
    .shadow_data_addr_i   (shadow_data_addr_i),
    .shadow_data_wdata_i  (shadow_data_wdata_i),
    .shadow_irq_pending_i (shadow_irq_pending_i),
    .shadow_busy_i        (shadow_busy_i),
    .mismatch_o           (mismatch)
  );

  // Any divergence, bus corruption or shadow fault is fatal
  assign alert_major_o = mismatch | intg_err | shadow_alert_major_i;
  assign alert_minor_o = shadow_alert_minor_i;

endmodule

//--- hw/output_compare.sv
// Main requests are delayed LOCKSTEP_OFFSET+1 cycles; early stages hold X until cmp_en_i rises
`timescale 1ns/10ps
`include "lockstep_config.svh"

module output_compare #(
  parameter int unsigned LOCKSTEP_OFFSET = `LOCKSTEP_OFFSET
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                cmp_en_i,
  input  logic                core_instr_req_i,
  input  lockstep_pkg::word_t core_instr_addr_i,
  input  logic                core_data_req_i,
  input  logic                core_data_we_i,
  input  lockstep_pkg::be_t   core_data_be_i,
  input  lockstep_pkg::word_t core_data_addr_i,
  input  lockstep_pkg::word_t core_data_wdata_i,
  input  logic                core_irq_pending_i,
  input  logic                core_busy_i,
  input  logic                shadow_instr_req_i,
  input  lockstep_pkg::word_t shadow_instr_addr_i,
  input  logic                shadow_data_req_i,
  input  logic                shadow_data_we_i,
  input  lockstep_pkg::be_t   shadow_data_be_i,
  input  lockstep_pkg::word_t shadow_data_addr_i,
  input  lockstep_pkg::word_t shadow_data_wdata_i,
  input  logic                shadow_irq_pending_i,
  input  logic                shadow_busy_i,
  output logic                mismatch_o
);
  import lockstep_pkg::*;

  // One extra stage matches the shadow output register
  localparam int unsigned CoreStages = LOCKSTEP_OFFSET + 1;

  typedef struct packed {
    logic  instr_req;
    word_t instr_addr;
    logic  data_req;
    logic  data_we;
    be_t   data_be;
    word_t data_addr;
    word_t data_wdata;
    logic  irq_pending;
    logic  busy;
  } req_bundle_t;

  req_bundle_t                  core_in, shadow_in, shadow_q;
  req_bundle_t [CoreStages-1:0] core_q;

  assign core_in = {core_instr_req_i, core_instr_addr_i, core_data_req_i, core_data_we_i,
                    core_data_be_i, core_data_addr_i, core_data_wdata_i,
                    core_irq_pending_i, core_busy_i};

  assign shadow_in = {shadow_instr_req_i, shadow_instr_addr_i, shadow_data_req_i,
                      shadow_data_we_i, shadow_data_be_i, shadow_data_addr_i,
                      shadow_data_wdata_i, shadow_irq_pending_i, shadow_busy_i};

  always_ff @(posedge clk_i) begin
    for (int unsigned i = 0; i < CoreStages - 1; i++) begin
      core_q[i] <= core_q[i+1];
    end
    core_q[CoreStages-1] <= core_in;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_q <= '0;
    end else begin
      shadow_q <= shadow_in;
    end
  end

  assign mismatch_o = cmp_en_i & (shadow_q != core_q[0]);

  // Unfilled delay stages must never reach an enabled comparison
  core_filled_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmp_en_i |-> !$isunknown(core_q[0]));

endmodule

//--- hw/resp_tap_if.sv
// Read responses here lag the bus by one cycle and carry no check bits
`timescale 1ns/10ps

interface resp_tap_if;
  import lockstep_pkg::*;

  logic  instr_rvalid;
  word_t instr_rdata;
  logic  data_rvalid;
  word_t data_rdata;

  // Newest delay-line stage
  modport tap (
    output instr_rvalid,
    output instr_rdata,
    output data_rvalid,
    output data_rdata
  );

  // Read-only view for the integrity check
  modport chk (
    input instr_rvalid,
    input instr_rdata,
    input data_rvalid,
    input data_rdata
  );

endinterface

//--- hw/shadow_reset_seq.sv
// LOCKSTEP_OFFSET must be at least 2 and fit offset_cnt_t; comparison starts one cycle after release
`timescale 1ns/10ps
`include "lockstep_config.svh"

module shadow_reset_seq #(
  parameter int unsigned LOCKSTEP_OFFSET = `LOCKSTEP_OFFSET
) (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no,
  output logic cmp_en_o
);
  import lockstep_pkg::*;

  seq_state_e  state_d, state_q;
  offset_cnt_t cnt_d, cnt_q;
  logic        cnt_done;

  if (LOCKSTEP_OFFSET < 2 || LOCKSTEP_OFFSET > 2**$bits(offset_cnt_t)) begin : g_offset_check
    $error("LOCKSTEP_OFFSET is below 2 or too large for offset_cnt_t");
  end

  assign cnt_done = (cnt_q == offset_cnt_t'(LOCKSTEP_OFFSET - 1));

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      SEQ_HOLD: begin
        if (cnt_done) begin
          state_d = SEQ_RELEASE;
        end else begin
          cnt_d = cnt_q + offset_cnt_t'(1);
        end
      end
      SEQ_RELEASE: state_d = SEQ_COMPARE;
      SEQ_COMPARE: state_d = SEQ_COMPARE;
      default:     state_d = SEQ_HOLD;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SEQ_HOLD;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Straight from the state register, no decode glitches
  assign shadow_rst_no = (state_q != SEQ_HOLD);
  assign cmp_en_o      = (state_q == SEQ_COMPARE);

  // Shadow must already be out of reset when comparison turns on
  cmp_after_release_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(cmp_en_o) |-> $past(shadow_rst_no));

endmodule

//--- verification/lockstep_checker.sv
// Samples on the falling edge; expects stimulus to change shortly after the rising edge
`timescale 1ns/10ps

module lockstep_checker #(
  parameter int unsigned N_TESTS = 1,
  parameter int unsigned WINDOW  = 6
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            test_start_i,
  input  logic [8*16-1:0] test_name_i,
  input  logic            exp_major_i,
  input  logic [2:0]      alert_at_i,
  input  logic            exp_minor_i,
  input  logic            alert_major_i,
  input  logic            alert_minor_i,
  input  logic            shadow_rst_n_i,
  input  logic [31:0]     data_wdata_i,
  input  logic [6:0]      data_wdata_intg_i,
  input  logic [75:0]     main_resp_i,
  input  logic [75:0]     shadow_resp_i,
  output int              err_cnt_o,
  output int              done_cnt_o
);
  import lockstep_pkg::*;

  logic [75:0]     in_s1, in_s2;
  int              edge_cnt;
  logic            active;
  int              cyc, fails_at_start, failed_tests;
  logic [8*16-1:0] name_q;
  logic            exp_major_q, exp_minor_q;
  logic [2:0]      alert_at_q;

  initial begin
    err_cnt_o    = 0;
    done_cnt_o   = 0;
    failed_tests = 0;
    active       = 1'b0;
    cyc          = 0;
  end

  function automatic logic [6:0] expected_check_bits(logic [31:0] data);
    logic [6:0] bits;
    for (int k = 0; k < 7; k++) begin
      bits[k] = ^(data & INTG_MASK[k]);
    end
    return bits;
  endfunction

  task automatic compare(input logic [8*16-1:0] name, input logic [31:0] exp,
                         input logic [31:0] act);
    if (exp !== act) begin
      $display("error %0s: expected %0h actual %0h", name, exp, act);
      err_cnt_o = err_cnt_o + 1;
    end
  endtask

  // Main inputs of the last two edges
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      edge_cnt <= 0;
      in_s1    <= '0;
      in_s2    <= '0;
    end else begin
      if (edge_cnt < 15) edge_cnt <= edge_cnt + 1;
      in_s2 <= in_s1;
      in_s1 <= main_resp_i;
    end
  end

  always @(negedge clk_i) begin
    compare("reset_release", 32'(edge_cnt >= 2), 32'(shadow_rst_n_i));
    compare("wdata_intg", 32'(expected_check_bits(data_wdata_i)), 32'(data_wdata_intg_i));
    // Bundle holds instr flags and word, data flags and word, then six control bits
    compare("shadow_irdata", in_s2[72:41], shadow_resp_i[72:41]);
    compare("shadow_drdata", in_s2[37:6], shadow_resp_i[37:6]);
    compare("shadow_flags", 32'({in_s2[75:73], in_s2[40:38], in_s2[5:0]}),
            32'({shadow_resp_i[75:73], shadow_resp_i[40:38], shadow_resp_i[5:0]}));
    if (test_start_i && !active) begin
      active         = 1'b1;
      cyc            = 0;
      fails_at_start = err_cnt_o;
      name_q         = test_name_i;
      exp_major_q    = exp_major_i;
      exp_minor_q    = exp_minor_i;
      alert_at_q     = alert_at_i;
    end
    if (active) begin
      compare(name_q, 32'(exp_major_q && (cyc == int'(alert_at_q))), 32'(alert_major_i));
      if (cyc == 0) compare(name_q, 32'(exp_minor_q), 32'(alert_minor_i));
      if (cyc == int'(WINDOW) - 1) begin
        if (err_cnt_o == fails_at_start) begin
          $display("test %0s: ok", name_q);
        end else begin
          $display("test %0s: failed", name_q);
          failed_tests = failed_tests + 1;
        end
        active     = 1'b0;
        done_cnt_o = done_cnt_o + 1;
        if (done_cnt_o == int'(N_TESTS)) begin
          $display("Tests %0d, failed %0d, errors %0d", done_cnt_o, failed_tests, err_cnt_o);
        end
      end
      cyc = cyc + 1;
    end else begin
      // Quiet outside a test, start-up included
      compare("quiet", 32'd0, 32'(alert_major_i));
    end
  end

endmodule

//--- verification/tb_lockstep.sv
// Runs lockstep_top with LOCKSTEP_OFFSET 2; the shadow core is a replay model that can flip one address bit
`timescale 1ns/10ps

module tb_lockstep;
  import lockstep_pkg::*;

  localparam int unsigned OFFSET  = 2;
  localparam int unsigned WINDOW  = 6;
  localparam int unsigned N_TESTS = 10;
  localparam int unsigned LIMIT   = N_TESTS * 10 + 50;

  typedef struct packed {
    logic [8*16-1:0] name;
    logic            fault;
    logic            corrupt;
    logic            instr_rvalid;
    logic            data_rvalid;
    logic            shadow_major;
    logic            shadow_minor;
    logic            exp_major;
    logic [2:0]      alert_at;
    logic            exp_minor;
  } test_row_t;

  typedef struct packed {
    logic  instr_req;
    word_t instr_addr;
    logic  data_req;
    logic  data_we;
    be_t   data_be;
    word_t data_addr;
    word_t data_wdata;
    logic  irq_pending;
    logic  busy;
  } req_t;

  logic  clk_i, rst_ni;
  logic  instr_req_i, data_req_i, data_we_i, irq_pending_i, busy_i;
  word_t instr_addr_i, data_addr_i, data_wdata_i, instr_rdata_i, data_rdata_i;
  be_t   data_be_i;
  intg_t data_wdata_intg_o, instr_rdata_intg_i, data_rdata_intg_i;
  logic  instr_gnt_i, instr_rvalid_i, instr_err_i, data_gnt_i, data_rvalid_i, data_err_i;
  logic  irq_software_i, irq_timer_i, irq_external_i, irq_nm_i, debug_req_i, fetch_enable_i;
  logic  shadow_rst_no;
  logic  shadow_instr_gnt_o, shadow_instr_rvalid_o, shadow_instr_err_o;
  logic  shadow_data_gnt_o, shadow_data_rvalid_o, shadow_data_err_o;
  word_t shadow_instr_rdata_o, shadow_data_rdata_o;
  logic  shadow_irq_software_o, shadow_irq_timer_o, shadow_irq_external_o, shadow_irq_nm_o;
  logic  shadow_debug_req_o, shadow_fetch_enable_o;
  logic  shadow_instr_req_i, shadow_data_req_i, shadow_data_we_i;
  logic  shadow_irq_pending_i, shadow_busy_i;
  word_t shadow_instr_addr_i, shadow_data_addr_i, shadow_data_wdata_i;
  be_t   shadow_data_be_i;
  logic  shadow_alert_minor_i, shadow_alert_major_i, alert_minor_o, alert_major_o;

  // Checker side
  logic            test_start;
  logic [8*16-1:0] test_name;
  logic            exp_major, exp_minor;
  logic [2:0]      alert_at;
  int              err_cnt, done_cnt;

  test_row_t tests [N_TESTS];
  req_t      hist [OFFSET];
  logic      fault_hist [OFFSET];
  int        cycle_cnt;

  lockstep_top #(.LOCKSTEP_OFFSET (OFFSET)) uut (.*);

  lockstep_checker #(.N_TESTS (N_TESTS), .WINDOW (WINDOW)) u_checker (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .test_start_i      (test_start),
    .test_name_i       (test_name),
    .exp_major_i       (exp_major),
    .alert_at_i        (alert_at),
    .exp_minor_i       (exp_minor),
    .alert_major_i     (alert_major_o),
    .alert_minor_i     (alert_minor_o),
    .shadow_rst_n_i    (shadow_rst_no),
    .data_wdata_i      (data_wdata_i),
    .data_wdata_intg_i (data_wdata_intg_o),
    .main_resp_i       ({instr_gnt_i, instr_rvalid_i, instr_err_i, instr_rdata_i,
                         data_gnt_i, data_rvalid_i, data_err_i, data_rdata_i,
                         irq_software_i, irq_timer_i, irq_external_i, irq_nm_i,
                         debug_req_i, fetch_enable_i}),
    .shadow_resp_i     ({shadow_instr_gnt_o, shadow_instr_rvalid_o, shadow_instr_err_o,
                         shadow_instr_rdata_o, shadow_data_gnt_o, shadow_data_rvalid_o,
                         shadow_data_err_o, shadow_data_rdata_o, shadow_irq_software_o,
                         shadow_irq_timer_o, shadow_irq_external_o, shadow_irq_nm_o,
                         shadow_debug_req_o, shadow_fetch_enable_o}),
    .err_cnt_o         (err_cnt),
    .done_cnt_o        (done_cnt)
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  function automatic intg_t parity_bits(word_t data);
    intg_t bits;
    for (int k = 0; k < $bits(intg_t); k++) begin
      bits[k] = ^(data & INTG_MASK[k]);
    end
    return bits;
  endfunction

  // One cycle of main-core traffic plus the shadow replay
  task automatic drive_cycle(input test_row_t row, input logic active);
    req_t  req;
    req_t  replay;
    word_t rnd;
    intg_t flip;
    rnd             = $urandom();
    req.instr_req   = rnd[0];
    req.instr_addr  = $urandom();
    req.data_req    = rnd[1];
    req.data_we     = rnd[2];
    req.data_be     = rnd[6:3];
    req.data_addr   = $urandom();
    req.data_wdata  = $urandom();
    req.irq_pending = rnd[7];
    req.busy        = rnd[8];
    if (!shadow_rst_no) begin
      // Shadow still in reset, outputs are junk
      replay = req_t'({$urandom(), $urandom(), $urandom(), $urandom()});
    end else begin
      replay = hist[0];
      replay.instr_addr[5] = replay.instr_addr[5] ^ fault_hist[0];
    end
    hist[0]       = hist[1];
    fault_hist[0] = fault_hist[1];
    hist[1]       = req;
    fault_hist[1] = active & row.fault;
    {instr_req_i, instr_addr_i, data_req_i, data_we_i, data_be_i, data_addr_i,
     data_wdata_i, irq_pending_i, busy_i} = req;
    {shadow_instr_req_i, shadow_instr_addr_i, shadow_data_req_i, shadow_data_we_i,
     shadow_data_be_i, shadow_data_addr_i, shadow_data_wdata_i, shadow_irq_pending_i,
     shadow_busy_i} = replay;
    flip               = '0;
    flip[0]            = active & row.corrupt;
    instr_rdata_i      = $urandom();
    instr_rdata_intg_i = parity_bits(instr_rdata_i) ^ flip;
    data_rdata_i       = $urandom();
    data_rdata_intg_i  = parity_bits(data_rdata_i) ^ (flip << 3);
    instr_rvalid_i     = active & row.instr_rvalid;
    data_rvalid_i      = active & row.data_rvalid;
    {instr_gnt_i, instr_err_i, data_gnt_i, data_err_i} = rnd[12:9];
    {irq_software_i, irq_timer_i, irq_external_i, irq_nm_i} = rnd[16:13];
    {debug_req_i, fetch_enable_i} = rnd[18:17];
    shadow_alert_major_i = active & row.shadow_major;
    shadow_alert_minor_i = active & row.shadow_minor;
    test_start = active;
    test_name  = row.name;
    exp_major  = row.exp_major;
    alert_at   = row.alert_at;
    exp_minor  = row.exp_minor;
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= int'(LIMIT)) begin
      $display("Timeout: the tests did not complete within %0d cycles", LIMIT);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    void'($urandom(24));
    cycle_cnt = 0;
    rst_ni    = 1'b0;
    for (int i = 0; i < int'(OFFSET); i++) begin
      hist[i]       = '0;
      fault_hist[i] = 1'b0;
    end
    //             name           flt cor irv drv smj smn exp at minor
    tests[0] = '{"match",        0,  0,  0,  0,  0,  0,  0,  0, 0};
    tests[1] = '{"intg_ok",      0,  0,  1,  1,  0,  0,  0,  0, 0};
    tests[2] = '{"intg_bad_instr", 0, 1, 1,  0,  0,  0,  1,  1, 0};
    tests[3] = '{"intg_bad_data", 0, 1,  0,  1,  0,  0,  1,  1, 0};
    tests[4] = '{"intg_no_valid", 0, 1,  0,  0,  0,  0,  0,  0, 0};
    tests[5] = '{"shadow_fault", 1,  0,  0,  0,  0,  0,  1,  3, 0};
    tests[6] = '{"shadow_major", 0,  0,  0,  0,  1,  0,  1,  0, 0};
    tests[7] = '{"shadow_minor", 0,  0,  0,  0,  0,  1,  0,  0, 1};
    tests[8] = '{"fault_again",  1,  0,  1,  1,  0,  0,  1,  3, 0};
    tests[9] = '{"match_again",  0,  0,  1,  1,  0,  0,  0,  0, 0};
    drive_cycle('0, 1'b0);
    repeat (8) begin
      @(posedge clk_i);
      #1;
      drive_cycle('0, 1'b0);
    end
    rst_ni = 1'b1;
    // Shadow release and start of comparison
    repeat (4) begin
      @(posedge clk_i);
      #1;
      drive_cycle('0, 1'b0);
    end
    for (int t = 0; t < int'(N_TESTS); t++) begin
      @(posedge clk_i);
      #1;
      drive_cycle(tests[t], 1'b1);
      repeat (WINDOW - 1) begin
        @(posedge clk_i);
        #1;
        drive_cycle('0, 1'b0);
      end
    end
    @(posedge clk_i);
    #1;
    drive_cycle('0, 1'b0);
    wait (done_cnt == int'(N_TESTS));
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
